// File: src/sigmoidPkg.sv
package sigmoidPkg;

	// datapath widths
	localparam int X_W     = 8;
	localparam int Y_W     = 16;
	localparam int SEG_W   = 3;
	localparam int NIB_W   = 4;
	localparam int SLOPE_W = 4;
	localparam int PROD_W  = 8;
	localparam int FUNC_W  = 10;

	// edges spent in each part of the pipe
	localparam int PREP_LAT = 2;
	localparam int MUL_LAT  = 2;
	localparam int OUT_LAT  = 2;

	// -128 has no magnitude in 8 bits, so it maps to a fixed word
	localparam logic [Y_W-1:0] SPECIAL_Y = 16'h024D;

	typedef logic [SEG_W-1:0]   segT;
	typedef logic [NIB_W-1:0]   nibT;
	typedef logic [SLOPE_W-1:0] slopeT;
	typedef logic [PROD_W-1:0]  prodT;
	typedef logic [FUNC_W-1:0]  funcT;
	typedef logic [Y_W-1:0]     yT;

	// control bits riding beside the data
	typedef struct packed {
		logic valid;
		logic sign;
		logic special;
	} sidebandT;

	// what the slope and intercept paths consume
	typedef struct packed {
		segT segment;
		nibT nibble;
	} operandT;

	// slope per segment, scaled 2^-6
	localparam slopeT SLOPE_TABLE [0:(1 << SEG_W) - 1] = '{
		4'd15,
		4'd14,
		4'd11,
		4'd8,
		4'd6,
		4'd4,
		4'd2,
		4'd1
	};

	// intercept per segment, scaled 2^-11
	localparam funcT INTERCEPT_TABLE [0:(1 << SEG_W) - 1] = '{
		10'h003,
		10'h0FD,
		10'h1DE,
		10'h28F,
		10'h30B,
		10'h364,
		10'h3A2,
		10'h3C8
	};

endpackage

// File: src/pipeDelay.sv
module pipeDelay #(
	parameter type T     = logic,
	parameter int  DEPTH = 1
) (
	input  logic clk,
	input  logic i_rstN,
	input  T     i_data,
	output T     o_data
);

	T stages [DEPTH];

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else begin
			stages[0] <= i_data;
			// shift toward the output end
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i - 1];
			end
		end
	end

	assign o_data = stages[DEPTH - 1];

endmodule

// File: src/operandPrep.sv
module operandPrep (
	input  logic                       clk,
	input  logic                       i_rstN,
	input  logic                       i_inValid,
	input  logic [sigmoidPkg::X_W-1:0] i_x,
	output sigmoidPkg::sidebandT       o_side,
	output sigmoidPkg::operandT        o_operand
);

	logic                       rawValid;
	logic [sigmoidPkg::X_W-1:0] rawX;
	logic                       sign;
	logic [sigmoidPkg::X_W-1:0] magnitude;

	// first edge just captures the input
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			rawValid <= 1'b0;
		end else begin
			rawValid <= i_inValid;
		end
	end

	always_ff @(posedge clk) begin
		rawX <= i_x;
	end

	assign sign = rawX[sigmoidPkg::X_W-1];

	// two's complement negate for negative inputs
	assign magnitude = sign ? (~rawX + 1'b1) : rawX;

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_side <= '0;
		end else begin
			o_side.valid   <= rawValid;
			o_side.sign    <= sign;
			// only -128 still has the top bit after negation
			o_side.special <= sign & magnitude[sigmoidPkg::X_W-1];
		end
	end

	always_ff @(posedge clk) begin
		o_operand.segment <= magnitude[sigmoidPkg::NIB_W +: sigmoidPkg::SEG_W];
		o_operand.nibble  <= magnitude[sigmoidPkg::NIB_W-1:0];
	end

endmodule

// File: src/slopeMultiplier.sv
module slopeMultiplier (
	input  logic                clk,
	input  logic                i_rstN,
	input  sigmoidPkg::operandT i_operand,
	output sigmoidPkg::prodT    o_product
);

	localparam int PSUM_W = sigmoidPkg::NIB_W + 2;

	sigmoidPkg::slopeT slope;
	sigmoidPkg::nibT   partial [sigmoidPkg::SLOPE_W];
	logic [PSUM_W-1:0] sum01;
	logic [PSUM_W-1:0] sum23;
	logic [PSUM_W-1:0] sum01Next;
	logic [PSUM_W-1:0] sum23Next;

	assign slope = sigmoidPkg::SLOPE_TABLE[i_operand.segment];

	// nibble gated by each slope bit
	always_comb begin
		for (int i = 0; i < sigmoidPkg::SLOPE_W; i++) begin
			partial[i] = i_operand.nibble & {sigmoidPkg::NIB_W{slope[i]}};
		end
	end

	// pairs of partial products, the odd one shifted by one
	assign sum01Next = {2'b00, partial[0]} + {1'b0, partial[1], 1'b0};
	assign sum23Next = {2'b00, partial[2]} + {1'b0, partial[3], 1'b0};

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			sum01 <= '0;
			sum23 <= '0;
		end else begin
			sum01 <= sum01Next;
			sum23 <= sum23Next;
		end
	end

	// second step, upper pair weighs 4
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_product <= '0;
		end else begin
			o_product <= {2'b00, sum01} + {sum23, 2'b00};
		end
	end

endmodule

// File: src/interceptLookup.sv
module interceptLookup #(
	parameter int SEG_DEPTH = 1
) (
	input  logic             clk,
	input  logic             i_rstN,
	input  sigmoidPkg::segT  i_segment,
	output sigmoidPkg::funcT o_intercept
);

	sigmoidPkg::segT segDelayed;

	// table is read one stage late, matching the multiplier's first step
	pipeDelay #(
		.T     (sigmoidPkg::segT),
		.DEPTH (SEG_DEPTH)
	) u_segDelay (
		.clk    (clk),
		.i_rstN (i_rstN),
		.i_data (i_segment),
		.o_data (segDelayed)
	);

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_intercept <= '0;
		end else begin
			o_intercept <= sigmoidPkg::INTERCEPT_TABLE[segDelayed];
		end
	end

endmodule

// File: src/outputCombine.sv
module outputCombine (
	input  logic                 clk,
	input  logic                 i_rstN,
	input  sigmoidPkg::sidebandT i_side,
	input  sigmoidPkg::prodT     i_product,
	input  sigmoidPkg::funcT     i_intercept,
	output sigmoidPkg::yT        o_y,
	output logic                 o_outValid
);

	sigmoidPkg::sidebandT       sideQ;
	sigmoidPkg::funcT           funcSum;
	sigmoidPkg::yT              word;
	logic [sigmoidPkg::Y_W-2:1] body;

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			sideQ <= '0;
		end else begin
			sideQ <= i_side;
		end
	end

	// wraps at 1024
	always_ff @(posedge clk) begin
		funcSum <= sigmoidPkg::funcT'(i_product) + i_intercept;
	end

	// negative side mirrors around one half
	always_comb begin
		if (sideQ.special) begin
			word = sigmoidPkg::SPECIAL_Y;
		end else begin
			word = {
				1'b0,
				~sideQ.sign,
				funcSum ^ {sigmoidPkg::FUNC_W{sideQ.sign}},
				sideQ.sign,
				3'b011
			};
		end
	end

	// body only loads on valid, so it reads zero until the first result
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			body       <= '0;
			o_outValid <= 1'b0;
		end else begin
			o_outValid <= sideQ.valid;
			if (sideQ.valid) begin
				body <= word[sigmoidPkg::Y_W-2:1];
			end
		end
	end

	// bit 0 always set, bit 15 always clear
	assign o_y = {1'b0, body, 1'b1};

endmodule

// File: src/sigmoidTop.sv
module sigmoidTop (
	input  logic                       clk,
	input  logic                       i_rstN,
	input  logic                       i_inValid,
	input  logic [sigmoidPkg::X_W-1:0] i_x,
	output sigmoidPkg::yT              o_y,
	output logic                       o_outValid
);

	sigmoidPkg::sidebandT prepSide;
	sigmoidPkg::sidebandT alignedSide;
	sigmoidPkg::operandT  prepOperand;
	sigmoidPkg::prodT     product;
	sigmoidPkg::funcT     intercept;

	operandPrep u_prep (
		.clk       (clk),
		.i_rstN    (i_rstN),
		.i_inValid (i_inValid),
		.i_x       (i_x),
		.o_side    (prepSide),
		.o_operand (prepOperand)
	);

	// slope path
	slopeMultiplier u_mul (
		.clk       (clk),
		.i_rstN    (i_rstN),
		.i_operand (prepOperand),
		.o_product (product)
	);

	// intercept path, one edge of delay plus its output register
	interceptLookup #(
		.SEG_DEPTH (sigmoidPkg::MUL_LAT - 1)
	) u_intercept (
		.clk         (clk),
		.i_rstN      (i_rstN),
		.i_segment   (prepOperand.segment),
		.o_intercept (intercept)
	);

	// sideband waits out the multiplier
	pipeDelay #(
		.T     (sigmoidPkg::sidebandT),
		.DEPTH (sigmoidPkg::MUL_LAT)
	) u_sideDelay (
		.clk    (clk),
		.i_rstN (i_rstN),
		.i_data (prepSide),
		.o_data (alignedSide)
	);

	outputCombine u_combine (
		.clk         (clk),
		.i_rstN      (i_rstN),
		.i_side      (alignedSide),
		.i_product   (product),
		.i_intercept (intercept),
		.o_y         (o_y),
		.o_outValid  (o_outValid)
	);

endmodule

// File: bench/sigmoidTop_chk.sv
module sigmoidTop_chk (
	input logic                       clk,
	input logic                       i_rstN,
	input logic                       i_inValid,
	input logic [sigmoidPkg::X_W-1:0] i_x,
	input logic                       i_outValid,
	input sigmoidPkg::yT              i_y
);

	localparam int LATENCY = sigmoidPkg::PREP_LAT + sigmoidPkg::MUL_LAT + sigmoidPkg::OUT_LAT;

	int assertFails = 0;
	// counts edges after reset release up to the latency
	int warmup = 0;

	always @(posedge clk) begin
		if (!i_rstN) begin
			warmup <= 0;
		end else if (warmup < LATENCY) begin
			warmup <= warmup + 1;
		end
	end

	resetQuiet: assert property (@(posedge clk) $rose(i_rstN) |-> !i_outValid)
		else begin
			assertFails++;
			$error("o_outValid high in the first cycle after reset");
		end

	// valid strobe comes out exactly LATENCY edges after it went in
	fixedLatency: assert property (@(posedge clk) disable iff (!i_rstN || warmup < LATENCY)
		i_outValid == $past(i_inValid, LATENCY))
		else begin
			assertFails++;
			$error("o_outValid does not follow i_inValid by %0d cycles", LATENCY);
		end

	// constant frame bits and the fixed word only for -128
	outputFrame: assert property (@(posedge clk) disable iff (!i_rstN)
		i_outValid |-> (i_y[0] && !i_y[15]
			&& (($past(i_x, LATENCY) == 8'h80) == (i_y == sigmoidPkg::SPECIAL_Y))))
		else begin
			assertFails++;
			$error("o_y frame bits or fixed word wrong while o_outValid is high");
		end

endmodule

bind sigmoidTop sigmoidTop_chk u_chk (
	.clk        (clk),
	.i_rstN     (i_rstN),
	.i_inValid  (i_inValid),
	.i_x        (i_x),
	.i_outValid (o_outValid),
	.i_y        (o_y)
);

// File: bench/sigmoidMonitor.sv
module sigmoidMonitor (
	input  logic                       clk,
	input  logic                       i_rstN,
	input  logic                       i_inValid,
	input  logic [sigmoidPkg::X_W-1:0] i_x,
	input  sigmoidPkg::yT              i_y,
	input  logic                       i_outValid,
	output int                         o_checks,
	output int                         o_errors,
	output int                         o_pending
);

	localparam int LATENCY = sigmoidPkg::PREP_LAT + sigmoidPkg::MUL_LAT + sigmoidPkg::OUT_LAT;

	typedef struct packed {
		logic [sigmoidPkg::X_W-1:0] x;
		sigmoidPkg::yT              y;
		logic [31:0]                stamp;
	} expectT;

	expectT expectQ [$];
	expectT entry;
	int     cycle = 0;
	int     checks = 0;
	int     errors = 0;
	int     pendingCount = 0;
	logic   seenOutput = 1'b0;

	// piecewise-linear sigmoid, mirrored around one half for negative x
	function automatic sigmoidPkg::yT refSigmoid(input logic [7:0] x);
		logic       s;
		logic [7:0] m;
		logic [2:0] seg;
		logic [3:0] nib;
		logic [9:0] f;
		s = x[7];
		if (x == 8'h80) begin
			return sigmoidPkg::SPECIAL_Y;
		end
		m = s ? 8'(8'd0 - x) : x;
		seg = m[6:4];
		nib = m[3:0];
		f = 10'(sigmoidPkg::SLOPE_TABLE[seg]) * 10'(nib) + sigmoidPkg::INTERCEPT_TABLE[seg];
		return {1'b0, ~s, f ^ {10{s}}, s, 3'b011};
	endfunction

	always @(posedge clk) begin
		if (i_rstN) begin
			cycle++;
			// idle word before the first result
			if (!seenOutput && !i_outValid) begin
				checks++;
				if (i_y !== 16'h0001) begin
					errors++;
					$display("ERR o_y: got %h expected %h before any output", i_y, 16'h0001);
				end
			end
			if (i_outValid) begin
				seenOutput = 1'b1;
				if (expectQ.size() == 0) begin
					errors++;
					$display("output valid at cycle %0d with no input waiting for it", cycle);
				end else begin
					entry = expectQ.pop_front();
					checks++;
					if (cycle - int'(entry.stamp) != LATENCY) begin
						errors++;
						$display("output for input %h took %0d cycles instead of %0d",
							entry.x, cycle - int'(entry.stamp), LATENCY);
					end
					if (i_y !== entry.y) begin
						errors++;
						$display("ERR o_y: got %h expected %h for input %h", i_y, entry.y, entry.x);
					end
				end
			end
			// anything older than the latency never came out
			while (expectQ.size() > 0 && cycle - int'(expectQ[0].stamp) > LATENCY) begin
				entry = expectQ.pop_front();
				errors++;
				$display("no output for input %h accepted at cycle %0d", entry.x, entry.stamp);
			end
			if (i_inValid) begin
				entry.x = i_x;
				entry.y = refSigmoid(i_x);
				entry.stamp = 32'(cycle);
				expectQ.push_back(entry);
			end
			pendingCount = expectQ.size();
		end
	end

	assign o_checks = checks;
	assign o_errors = errors;
	assign o_pending = pendingCount;

endmodule

// File: bench/sigmoidTb.sv
module sigmoidTb;

	localparam int CLK_PERIOD    = 40;
	localparam int RESET_CYCLES  = 3;
	localparam int IDLE_CYCLES   = 8;
	localparam int SWEEP_CYCLES  = 256;
	localparam int RANDOM_CYCLES = 400;
	localparam int LATENCY = sigmoidPkg::PREP_LAT + sigmoidPkg::MUL_LAT + sigmoidPkg::OUT_LAT;
	// all stimulus, two flushes and slack
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + SWEEP_CYCLES
		+ RANDOM_CYCLES + 4 * LATENCY + 300;

	logic          clk;
	logic          rstN;
	logic          inValid;
	logic [7:0]    x;
	sigmoidPkg::yT y;
	logic          outValid;
	int            checks;
	int            errors;
	int            pending;
	int            assertFails;
	int            cycleCount = 0;
	logic [31:0]   lfsrState = 32'hf772e3b5;

	// right-shift Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	task automatic takeBits(input int count, output logic [7:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[6:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	sigmoidTop u_dut (
		.clk        (clk),
		.i_rstN     (rstN),
		.i_inValid  (inValid),
		.i_x        (x),
		.o_y        (y),
		.o_outValid (outValid)
	);

	sigmoidMonitor u_monitor (
		.clk        (clk),
		.i_rstN     (rstN),
		.i_inValid  (inValid),
		.i_x        (x),
		.i_y        (y),
		.i_outValid (outValid),
		.o_checks   (checks),
		.o_errors   (errors),
		.o_pending  (pending)
	);

	assign assertFails = u_dut.u_chk.assertFails;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == TIMEOUT_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial begin
		logic [7:0] validBit;
		logic [7:0] data;
		rstN <= 1'b0;
		inValid <= 1'b0;
		x <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		// quiet period, monitor watches the reset word
		repeat (IDLE_CYCLES) @(posedge clk);
		for (int v = 0; v < SWEEP_CYCLES; v++) begin
			@(posedge clk);
			inValid <= 1'b1;
			x <= 8'(v);
		end
		// random gaps and data
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			@(posedge clk);
			takeBits(1, validBit);
			takeBits(8, data);
			inValid <= validBit[0];
			x <= data;
		end
		@(posedge clk);
		inValid <= 1'b0;
		@(negedge clk);
		while (pending != 0) @(negedge clk);
		// stray outputs would show up here
		repeat (LATENCY + 2) @(negedge clk);
		$display("checks %0d, errors %0d, assertion failures %0d, pending %0d",
			checks, errors, assertFails, pending);
		if (errors == 0 && assertFails == 0 && pending == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
src/sigmoidPkg.sv
src/pipeDelay.sv
src/operandPrep.sv
src/slopeMultiplier.sv
src/interceptLookup.sv
src/outputCombine.sv
src/sigmoidTop.sv
bench/sigmoidTop_chk.sv
bench/sigmoidMonitor.sv
bench/sigmoidTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the sigmoid testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module sigmoidTb -Mdir obj_dir -f src.f

# keep running past assertion errors so the testbench can report them
./obj_dir/VsigmoidTb +verilator+error+limit+1000 | tee /dev/stderr \
	| grep -x "ALL TESTS PASSED" > /dev/null

echo "simulation passed"
